// ==== bench/codeLockTable.svh ====
// columns: test name, reset first, keys, secret, expected digits 3 to 0
// keys are hex, A is clear, B is enter, C to F do nothing;
// R types a random wrong code plus enter, r the code alone; * is a digit of that code
task automatic loadRows();
	addRow("afterReset", 1'b1, "", 12'h357, "0   ");
	addRow("oneDigit", 1'b0, "1", 12'h357, "0  1");
	addRow("twoDigits", 1'b0, "2", 12'h357, "0 12");
	addRow("threeDigits", 1'b0, "4", 12'h357, "0124");
	addRow("fourthDigit", 1'b0, "9", 12'h357, "0124");
	addRow("clearEntry", 1'b0, "A", 12'h357, "0   ");
	addRow("shortEnter", 1'b0, "56B", 12'h357, "0 56");
	addRow("ignoredKeys", 1'b0, "CDEF", 12'h357, "0 56");
	addRow("clearAgain", 1'b0, "A", 12'h357, "0   ");
	addRow("wrongFixed", 1'b0, "123B", 12'h357, "1   ");
	addRow("randomTyped", 1'b0, "r", 12'h357, "1***");
	addRow("randomEnter", 1'b0, "B", 12'h357, "2   ");
	addRow("randomWrong", 1'b0, "RR", 12'h357, "4   ");
	addRow("correctCode", 1'b0, "357B", 12'h357, "PASS");
	addRow("keysAfterPass", 1'b0, "A12B", 12'h357, "PASS");
	addRow("wrongAfterReset", 1'b1, "111B222B", 12'h357, "2   ");
	addRow("moreWrong", 1'b0, "RRR", 12'h357, "5   ");
	addRow("lockout", 1'b0, "R", 12'h357, "----");
	addRow("correctWhileLocked", 1'b0, "357B", 12'h357, "----");
	addRow("resetAfterLock", 1'b1, "", 12'h357, "0   ");
	addRow("newSecret", 1'b1, "840B", 12'h840, "PASS");
endtask

// ==== bench/codeLockTb.sv ====
`timescale 1ns/100ps

module codeLockTb;

	localparam int SCAN_BITS = 3;
	localparam int SLOT_CYCLES = 1 << SCAN_BITS;
	localparam int SCAN_CYCLES = 4 * SLOT_CYCLES; // all four digits once
	localparam int RESET_CYCLES = 10;
	localparam int MAX_STROBES = 48; // twelve chars, four strobes each at most
	localparam int CLK_PERIOD = 100;

	logic CLK = 1'b0;
	logic rstN = 1'b0;
	logic keyValid = 1'b0;
	logic [3:0] key = 4'h0;
	logic [11:0] secret = 12'h000;
	logic [7:0] segments;
	logic [3:0] digitSel;

	string rowName[$];
	bit rowReset[$];
	string rowKeys[$];
	logic [11:0] rowSecret[$];
	string rowShown[$];
	logic [31:0] lfsrState = 32'hb61f3ce9;
	logic [11:0] lastRandom = 12'h000; // last random code typed
	int errorCount = 0;

	codeLock #(.scanBits(SCAN_BITS)) dut
	(
		.CLK(CLK),
		.rstN(rstN),
		.keyValid(keyValid),
		.key(key),
		.secret(secret),
		.segments(segments),
		.digitSel(digitSel)
	);

	initial
	begin
		forever #(CLK_PERIOD / 2) CLK = ~CLK;
	end

	task automatic addRow(input string name, input bit doReset, input string keys,
		input logic [11:0] code, input string shown);
		rowName.push_back(name);
		rowReset.push_back(doReset);
		rowKeys.push_back(keys);
		rowSecret.push_back(code);
		rowShown.push_back(shown);
	endtask

	`include "codeLockTable.svh"

	task automatic failRun(input string why);
		errorCount++;
		$display("%s", why);
		$display("Done: errors found");
		$fatal(1);
	endtask

	task automatic checkEqual(input string name, input logic [7:0] expected,
		input logic [7:0] actual);
		if (actual !== expected)
			failRun($sformatf("MISMATCH %s expected %h actual %h", name, expected, actual));
	endtask

	// taps x^32+x^22+x^2+x+1
	function automatic logic [31:0] galoisStep(input logic [31:0] s);
		if (s[0])
			return (s >> 1) ^ 32'h80200003;
		return s >> 1;
	endfunction

	task automatic drawWrongCode(input logic [11:0] avoid, output logic [11:0] code);
		logic [3:0] digit;
		code = avoid;
		while (code == avoid)
		begin
			for (int d = 0; d < 3; d++)
			begin
				digit = 4'hF;
				while (digit > 4'd9) // redraw until decimal
				begin
					for (int b = 0; b < 4; b++)
					begin
						digit = {digit[2:0], lfsrState[0]};
						lfsrState = galoisStep(lfsrState);
					end
				end
				code = {code[7:0], digit};
			end
		end
	endtask

	function automatic logic [3:0] hexValue(input byte c);
		if (c >= "0" && c <= "9")
			return 4'(c - "0");
		return 4'(c - "A" + 10);
	endfunction

	function automatic logic [7:0] glyphFor(input byte c, input int slot);
		case (c)
			" ": return codeLockPkg::GLYPH_BLANK;
			"-": return codeLockPkg::GLYPH_DASH;
			"P": return codeLockPkg::GLYPH_P;
			"A": return codeLockPkg::GLYPH_A;
			"S": return codeLockPkg::GLYPH_S;
			"*": return codeLockPkg::GLYPH_DIGIT[lastRandom[slot*4 +: 4]];
			default: return codeLockPkg::GLYPH_DIGIT[hexValue(c)];
		endcase
	endfunction

	task automatic pressKey(input logic [3:0] value);
		@(posedge CLK);
		keyValid <= 1'b1;
		key <= value;
		@(posedge CLK);
		keyValid <= 1'b0; // idle cycle before the next key
	endtask

	task automatic applyKeys(input string keys, input logic [11:0] code);
		byte c;
		for (int i = 0; i < keys.len(); i++)
		begin
			c = keys[i];
			if (c == "R" || c == "r")
			begin
				drawWrongCode(code, lastRandom);
				pressKey(lastRandom[11:8]); // first typed ends up leftmost
				pressKey(lastRandom[7:4]);
				pressKey(lastRandom[3:0]);
				if (c == "R")
					pressKey(4'hB);
			end
			else
				pressKey(hexValue(c));
		end
	endtask

	task automatic sampleDisplay(input int row);
		int slot;
		int lastSlot;
		string shown;
		shown = rowShown[row];
		lastSlot = -1;
		repeat (2 * SCAN_CYCLES) @(posedge CLK);
		for (int n = 0; n < 4; n++)
		begin
			@(negedge CLK);
			case (digitSel)
				4'b1110: slot = 0;
				4'b1101: slot = 1;
				4'b1011: slot = 2;
				4'b0111: slot = 3;
				default: slot = -1;
			endcase
			if (slot < 0)
				failRun($sformatf("%s: digit select %b does not have exactly one low bit",
					rowName[row], digitSel));
			else
			begin
				if (lastSlot >= 0)
					checkEqual($sformatf("%s scan order", rowName[row]),
						8'((lastSlot + 1) % 4), 8'(slot));
				checkEqual($sformatf("%s digit %0d", rowName[row], slot),
					glyphFor(shown[3 - slot], slot), segments);
				lastSlot = slot;
			end
			repeat (SLOT_CYCLES - 1) @(negedge CLK); // next slot
		end
	endtask

	initial
	begin
		loadRows();
		for (int i = 0; i < rowName.size(); i++)
		begin
			@(posedge CLK);
			secret <= rowSecret[i];
			if (rowReset[i])
			begin
				rstN <= 1'b0;
				repeat (RESET_CYCLES) @(posedge CLK);
				rstN <= 1'b1;
			end
			applyKeys(rowKeys[i], rowSecret[i]);
			sampleDisplay(i);
		end
		if (errorCount == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

	// watchdog
	initial
	begin
		longint limitCycles;
		#1;
		limitCycles = longint'(rowName.size())
			* (2 * MAX_STROBES + 3 * SCAN_CYCLES + RESET_CYCLES + 20);
		#(limitCycles * CLK_PERIOD);
		failRun("watchdog expired, the simulation hung");
	end

endmodule

// ==== codeLock.f ====
+incdir+bench
design/codeLockPkg.sv
design/panelIf.sv
design/digitEntry.sv
design/codeChecker.sv
design/segmentScanner.sv
design/codeLock.sv
bench/codeLockTb.sv

// ==== design/codeChecker.sv ====
`timescale 1ns/100ps

module codeChecker
(
	input logic CLK,
	input logic rstN,
	input logic [11:0] code,
	input logic [1:0] digitCount,
	input logic submit,
	input logic [11:0] secret,
	panelIf.checkStage panel
);

	codeLockPkg::verdict state;
	codeLockPkg::verdict nextState;
	logic [3:0] tries;
	logic [3:0] nextTries;
	logic codeMatch;

	assign codeMatch = (code == secret);

	always_comb
	begin
		nextState = state;
		nextTries = tries;
		case (state)
			codeLockPkg::vEntering:
			begin
				if (submit)
				begin
					if (codeMatch)
					begin
						nextState = codeLockPkg::vPassed;
					end
					else
					begin
						nextTries = tries + 4'd1;
						if (nextTries == 4'(codeLockPkg::MAX_TRIES))
						begin
							nextState = codeLockPkg::vLockedOut;
						end
					end
				end
			end
			default:
			begin
				nextState = state; // only reset leaves here
			end
		endcase
	end

	always_ff @(posedge CLK or negedge rstN)
	begin
		if (!rstN)
		begin
			state <= codeLockPkg::vEntering;
			tries <= 4'd0;
			panel.digitCount <= 2'd0;
			panel.shownCode <= 12'h000;
		end
		else
		begin
			state <= nextState;
			tries <= nextTries;
			panel.digitCount <= digitCount; // one cycle behind entry
			panel.shownCode <= code;
		end
	end

	assign panel.state = state;
	assign panel.tries = tries;

	assert property (@(posedge CLK) disable iff (!rstN)
		tries <= 4'(codeLockPkg::MAX_TRIES));

	// pass and lockout are sticky until reset
	assert property (@(posedge CLK) disable iff (!rstN)
		state == codeLockPkg::vPassed |=> state == codeLockPkg::vPassed);

	assert property (@(posedge CLK) disable iff (!rstN)
		state == codeLockPkg::vLockedOut |=> state == codeLockPkg::vLockedOut);

endmodule

// ==== design/codeLock.sv ====
`timescale 1ns/100ps

module codeLock
#(
	parameter int scanBits = 16 // small in simulation
)
(
	input logic CLK,
	input logic rstN,
	input logic keyValid,
	input logic [3:0] key,
	input logic [11:0] secret,
	output logic [7:0] segments,
	output logic [3:0] digitSel
);

	logic [11:0] code;
	logic [1:0] digitCount;
	logic submit;

	panelIf panel();

	digitEntry entry
	(
		.CLK(CLK),
		.rstN(rstN),
		.keyValid(keyValid),
		.key(codeLockPkg::keyCode'(key)),
		.code(code),
		.digitCount(digitCount),
		.submit(submit)
	);

	codeChecker check
	(
		.CLK(CLK),
		.rstN(rstN),
		.code(code),
		.digitCount(digitCount),
		.submit(submit),
		.secret(secret),
		.panel(panel.checkStage)
	);

	segmentScanner #(
		.scanBits(scanBits)
	) scan
	(
		.CLK(CLK),
		.rstN(rstN),
		.panel(panel.scanner),
		.segments(segments),
		.digitSel(digitSel)
	);

endmodule

// ==== design/codeLockPkg.sv ====
package codeLockPkg;

	// keypad values, strobed in by the top level
	typedef enum logic [3:0]
	{
		keyD0 = 4'h0,
		keyD1 = 4'h1,
		keyD2 = 4'h2,
		keyD3 = 4'h3,
		keyD4 = 4'h4,
		keyD5 = 4'h5,
		keyD6 = 4'h6,
		keyD7 = 4'h7,
		keyD8 = 4'h8,
		keyD9 = 4'h9,
		keyClear = 4'hA,
		keyEnter = 4'hB,
		keyRsvC = 4'hC, // C to F do nothing
		keyRsvD = 4'hD,
		keyRsvE = 4'hE,
		keyRsvF = 4'hF
	} keyCode;

	// lock status as seen by the display
	typedef enum logic [1:0]
	{
		vEntering = 2'd0,
		vPassed = 2'd1,
		vLockedOut = 2'd2
	} verdict;

	localparam int CODE_DIGITS = 3; // digits per code
	localparam int MAX_TRIES = 6; // wrong tries before lockout

	// segment patterns, active high, bit 7 is dp (never lit)
	localparam logic [7:0] GLYPH_DIGIT [16] = '{
		8'h3f, 8'h06, 8'h5b, 8'h4f, // 0 1 2 3
		8'h66, 8'h6d, 8'h7d, 8'h07, // 4 5 6 7
		8'h7f, 8'h6f, 8'h77, 8'h7c, // 8 9 A b
		8'h39, 8'h5e, 8'h79, 8'h71 // C d E F
	};

	localparam logic [7:0] GLYPH_P = 8'h73;
	localparam logic [7:0] GLYPH_A = 8'h77;
	localparam logic [7:0] GLYPH_S = 8'h6d;
	localparam logic [7:0] GLYPH_DASH = 8'h40; // middle bar only
	localparam logic [7:0] GLYPH_BLANK = 8'h00;

	// hex value to its glyph
	function automatic logic [7:0] segmentOf(input logic [3:0] value);
		return GLYPH_DIGIT[value];
	endfunction

endpackage

// ==== design/digitEntry.sv ====
`timescale 1ns/100ps

module digitEntry
(
	input logic CLK,
	input logic rstN,
	input logic keyValid,
	input codeLockPkg::keyCode key,
	output logic [11:0] code,
	output logic [1:0] digitCount,
	output logic submit
);

	logic digitKey;
	logic roomLeft;
	logic codeFull;
	logic acceptDigit;
	logic acceptEnter;
	logic acceptClear;

	// key decode
	assign digitKey = (key <= codeLockPkg::keyD9);
	assign roomLeft = (digitCount < 2'(codeLockPkg::CODE_DIGITS));
	assign codeFull = (digitCount == 2'(codeLockPkg::CODE_DIGITS));

	assign acceptDigit = keyValid && digitKey && roomLeft; // 4th digit dropped
	assign acceptEnter = keyValid && (key == codeLockPkg::keyEnter) && codeFull;
	assign acceptClear = keyValid && (key == codeLockPkg::keyClear);

	always_ff @(posedge CLK or negedge rstN)
	begin
		if (!rstN)
		begin
			code <= 12'h000;
			digitCount <= 2'd0;
			submit <= 1'b0;
		end
		else
		begin
			submit <= acceptEnter; // one cycle only
			if (acceptClear)
			begin
				code <= 12'h000;
				digitCount <= 2'd0;
			end
			else if (acceptEnter)
			begin
				// code stays put so the checker can compare it while submit is high;
				// with the count at zero none of it is shown
				digitCount <= 2'd0;
			end
			else if (acceptDigit)
			begin
				code <= {code[7:0], key}; // first digit ends up leftmost
				digitCount <= digitCount + 2'd1;
			end
		end
	end

	// count saturates at a full code
	assert property (@(posedge CLK) disable iff (!rstN)
		digitCount <= 2'(codeLockPkg::CODE_DIGITS));

endmodule

// ==== design/panelIf.sv ====
`timescale 1ns/100ps

// display content from the check stage to the scan stage, level held
interface panelIf;

	logic [11:0] shownCode; // typed digits, latest in nibble 0
	logic [1:0] digitCount; // how many nibbles are valid
	logic [3:0] tries; // wrong tries so far
	codeLockPkg::verdict state;

	modport checkStage
	(
		output shownCode,
		output digitCount,
		output tries,
		output state
	);

	modport scanner
	(
		input shownCode,
		input digitCount,
		input tries,
		input state
	);

endinterface

// ==== design/segmentScanner.sv ====
`timescale 1ns/100ps

module segmentScanner
#(
	parameter int scanBits = 16
)
(
	input logic CLK,
	input logic rstN,
	panelIf.scanner panel,
	output logic [7:0] segments,
	output logic [3:0] digitSel
);

	logic [scanBits+1:0] refresh;
	logic [1:0] slot;
	logic [3:0] slotNibble;
	logic [3:0] selNext;
	logic [7:0] slotGlyph;

	assign slot = refresh[scanBits+1:scanBits]; // top two bits pick the digit

	always_comb
	begin
		case (slot)
			2'd0: selNext = 4'b1110;
			2'd1: selNext = 4'b1101;
			2'd2: selNext = 4'b1011;
			default: selNext = 4'b0111;
		endcase
	end

	// digit i shows nibble i, so typed digits sit right-aligned
	always_comb
	begin
		case (slot)
			2'd0: slotNibble = panel.shownCode[3:0];
			2'd1: slotNibble = panel.shownCode[7:4];
			2'd2: slotNibble = panel.shownCode[11:8];
			default: slotNibble = 4'h0;
		endcase
	end

	always_comb
	begin
		slotGlyph = codeLockPkg::GLYPH_BLANK;
		case (panel.state)
			codeLockPkg::vPassed:
			begin
				case (slot)
					2'd3: slotGlyph = codeLockPkg::GLYPH_P;
					2'd2: slotGlyph = codeLockPkg::GLYPH_A;
					default: slotGlyph = codeLockPkg::GLYPH_S;
				endcase
			end
			codeLockPkg::vLockedOut:
			begin
				slotGlyph = codeLockPkg::GLYPH_DASH;
			end
			default:
			begin
				if (slot == 2'd3)
					slotGlyph = codeLockPkg::segmentOf(panel.tries); // status digit
				else if (slot < panel.digitCount)
					slotGlyph = codeLockPkg::segmentOf(slotNibble);
			end
		endcase
	end

	// select and pattern leave together
	always_ff @(posedge CLK or negedge rstN)
	begin
		if (!rstN)
		begin
			refresh <= '0;
			digitSel <= 4'b1110;
			segments <= codeLockPkg::GLYPH_BLANK;
		end
		else
		begin
			refresh <= refresh + 1'b1;
			digitSel <= selNext;
			segments <= slotGlyph;
		end
	end

	assert property (@(posedge CLK) disable iff (!rstN)
		$onehot(~digitSel));

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log
verilator --binary --timing --assert -Wno-fatal --top-module codeLockTb \
	-f codeLock.f -o codeLockSim > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/codeLockSim > sim.log 2>&1
cat sim.log
grep -q "Done: errors found" sim.log && { echo "simulation FAILED"; exit 1; }
grep -q "Done: no errors" sim.log || { echo "simulation gave no result"; exit 1; }
echo "simulation passed"
